// ==== scope_config.svh ====
// Scope acquisition configuration
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

// ==========================================================
// Capture buffer geometry
// ==========================================================

// Buffer address width
`define SCOPE_ADDR_W 10
// Buffer depth in samples
`define SCOPE_DEPTH 1024
// Samples written after the trigger sample
`define SCOPE_POST_COUNT 512
// Samples written after arming before a trigger is taken
`define SCOPE_PRE_COUNT (`SCOPE_DEPTH - `SCOPE_POST_COUNT)

// ==========================================================
// Sample and time-base widths
// ==========================================================

// ADC sample width
`define SCOPE_DATA_W 8
// Time-base select width for decimation up to 2^(2^W - 1)
`define SCOPE_TB_W 3

`endif

// ==== scope_pkg.sv ====
// Scope acquisition types
`default_nettype none

`include "scope_config.svh"

package scope_pkg;

    // ==========================================================
    // Pipeline word
    // ==========================================================

    // One sample as it moves between stages
    typedef struct packed {
        // Sample present this cycle
        logic                      valid;
        // Sample is the trigger point
        logic                      trig;
        // ADC code
        logic [`SCOPE_DATA_W-1:0]  data;
    } sample_t;

    // Trigger edge select
    typedef enum logic {
        slope_rising,
        slope_falling
    } slope_e;

    // ==========================================================
    // Capture control
    // ==========================================================

    // Capture FSM states
    typedef enum logic [1:0] {
        st_arming,
        st_wait_trig,
        st_post_fill,
        st_hold
    } capture_state_e;

    // Status seen by the reader
    typedef struct packed {
        capture_state_e            state;
        // Buffer frozen and ready to read
        logic                      capture_ready;
        // Address of the trigger sample
        logic [`SCOPE_ADDR_W-1:0]  trig_addr;
    } capture_status_t;

endpackage

`default_nettype wire

// ==== sample_decimator.sv ====
// Time-base sample decimator
`default_nettype none
`timescale 1ns/1ps

`include "scope_config.svh"

module sample_decimator (
    input  wire                      ADC_CLK,
    input  wire                      MASTER_RST,
    input  wire [`SCOPE_DATA_W-1:0]  adc_data,
    input  wire [`SCOPE_TB_W-1:0]    time_base,
    output scope_pkg::sample_t       sample
);

    // Counter wide enough for the largest divide ratio
    localparam int CNT_W = (1 << `SCOPE_TB_W) - 1;

    logic [CNT_W-1:0]          div_cnt;
    logic [CNT_W-1:0]          div_eff;
    logic [CNT_W-1:0]          div_last;
    logic [`SCOPE_TB_W-1:0]    tb_last;
    logic                      tb_change;
    logic                      strobe;

    logic                      out_valid;
    logic [`SCOPE_DATA_W-1:0]  out_data;

    // ==========================================================
    // Divider
    // ==========================================================

    // Terminal count is 2^time_base - 1
    assign div_last = CNT_W'((1 << time_base) - 1);

    // A new time base restarts the count on this very cycle
    assign tb_change = (time_base != tb_last);
    assign div_eff   = tb_change ? '0 : div_cnt;

    // Fires every cycle when time_base is 0
    assign strobe = (div_eff == div_last);

    always_ff @(posedge ADC_CLK or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            div_cnt   <= '0;
            tb_last   <= '0;
            out_valid <= 1'b0;
        end else begin
            tb_last   <= time_base;
            out_valid <= strobe;
            // Wrap on the strobe
            if (strobe) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_eff + 1'b1;
            end
        end
    end

    // ==========================================================
    // Sample register
    // ==========================================================

    // ADC byte captured on the wrap cycle
    always_ff @(posedge ADC_CLK) begin
        if (strobe) begin
            out_data <= adc_data;
        end
    end

    // Decimator never marks a trigger
    assign sample.valid = out_valid;
    assign sample.trig  = 1'b0;
    assign sample.data  = out_data;

endmodule

`default_nettype wire

// ==== trigger_detector.sv ====
// Level and slope trigger
`default_nettype none
`timescale 1ns/1ps

`include "scope_config.svh"

module trigger_detector (
    input  wire                      ADC_CLK,
    input  wire                      MASTER_RST,
    input  wire scope_pkg::sample_t  sample_in,
    input  wire [`SCOPE_DATA_W-1:0]  trig_level,
    input  wire scope_pkg::slope_e   slope,
    input  wire                      force_trig,
    output scope_pkg::sample_t       sample_out
);

    // Last valid sample for the edge compare
    logic [`SCOPE_DATA_W-1:0]  prev_data;
    logic                      have_prev;
    // Force request waiting for a sample
    logic                      force_pend;

    logic                      level_hit;
    logic                      force_hit;

    logic                      out_valid;
    logic                      out_trig;
    logic [`SCOPE_DATA_W-1:0]  out_data;

    // ==========================================================
    // Trigger decision
    // ==========================================================

    always_comb begin
        level_hit = 1'b0;
        // No edge without a previous sample
        if (have_prev) begin
            if (slope == scope_pkg::slope_rising) begin
                level_hit = (prev_data < trig_level) && (sample_in.data >= trig_level);
            end else begin
                level_hit = (prev_data >= trig_level) && (sample_in.data < trig_level);
            end
        end
    end

    // Pulse in this cycle counts as well
    assign force_hit = force_pend | force_trig;

    always_ff @(posedge ADC_CLK or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            have_prev  <= 1'b0;
            force_pend <= 1'b0;
            out_valid  <= 1'b0;
            out_trig   <= 1'b0;
        end else begin
            out_valid <= sample_in.valid;
            out_trig  <= sample_in.valid & (sample_in.trig | level_hit | force_hit);
            if (sample_in.valid) begin
                have_prev  <= 1'b1;
                // Request consumed by this sample
                force_pend <= 1'b0;
            end else if (force_trig) begin
                force_pend <= 1'b1;
            end
        end
    end

    // Payload path
    always_ff @(posedge ADC_CLK) begin
        out_data <= sample_in.data;
        if (sample_in.valid) begin
            prev_data <= sample_in.data;
        end
    end

    assign sample_out.valid = out_valid;
    assign sample_out.trig  = out_trig;
    assign sample_out.data  = out_data;

endmodule

`default_nettype wire

// ==== capture_controller.sv ====
// Circular buffer capture FSM
`default_nettype none
`timescale 1ns/1ps

`include "scope_config.svh"

module capture_controller (
    input  wire                          ADC_CLK,
    input  wire                          MASTER_RST,
    input  wire scope_pkg::sample_t      sample_in,
    input  wire                          read_done,
    output logic                         wr_en,
    output logic [`SCOPE_ADDR_W-1:0]     wr_addr,
    output logic [`SCOPE_DATA_W-1:0]     wr_data,
    output scope_pkg::capture_status_t   status
);

    // Terminal counts for the shared counter
    localparam logic [`SCOPE_ADDR_W-1:0] PRE_LAST  = `SCOPE_ADDR_W'(`SCOPE_PRE_COUNT - 1);
    localparam logic [`SCOPE_ADDR_W-1:0] POST_LAST = `SCOPE_ADDR_W'(`SCOPE_POST_COUNT - 1);
    localparam logic [`SCOPE_ADDR_W-1:0] ADDR_LAST = `SCOPE_ADDR_W'(`SCOPE_DEPTH - 1);

    scope_pkg::capture_state_e  state;
    scope_pkg::capture_state_e  state_nxt;

    // Circular write pointer
    logic [`SCOPE_ADDR_W-1:0]   addr;
    // Arming and post-fill count
    logic [`SCOPE_ADDR_W-1:0]   cnt;
    logic                       cnt_clr;
    logic [`SCOPE_ADDR_W-1:0]   trig_addr;
    logic                       trig_take;
    logic                       write;

    // ==========================================================
    // Write port
    // ==========================================================

    // Buffer frozen while holding
    assign write   = sample_in.valid && (state != scope_pkg::st_hold);

    // Same cycle as the valid sample
    assign wr_en   = write;
    assign wr_addr = addr;
    assign wr_data = sample_in.data;

    // ==========================================================
    // Next state
    // ==========================================================

    always_comb begin
        state_nxt = state;
        cnt_clr   = 1'b0;
        trig_take = 1'b0;
        unique case (state)
            scope_pkg::st_arming: begin
                // Pre-trigger history filled
                if (write && cnt == PRE_LAST) begin
                    state_nxt = scope_pkg::st_wait_trig;
                    cnt_clr   = 1'b1;
                end
            end
            scope_pkg::st_wait_trig: begin
                // First tagged sample wins
                if (write && sample_in.trig) begin
                    state_nxt = scope_pkg::st_post_fill;
                    cnt_clr   = 1'b1;
                    trig_take = 1'b1;
                end
            end
            scope_pkg::st_post_fill: begin
                if (write && cnt == POST_LAST) begin
                    state_nxt = scope_pkg::st_hold;
                    cnt_clr   = 1'b1;
                end
            end
            scope_pkg::st_hold: begin
                // Reader finished so rearm
                if (read_done) begin
                    state_nxt = scope_pkg::st_arming;
                    cnt_clr   = 1'b1;
                end
            end
            default: begin
                state_nxt = scope_pkg::st_arming;
                cnt_clr   = 1'b1;
            end
        endcase
    end

    // ==========================================================
    // Registers
    // ==========================================================

    always_ff @(posedge ADC_CLK or posedge MASTER_RST) begin
        if (MASTER_RST) begin
            state     <= scope_pkg::st_arming;
            addr      <= '0;
            cnt       <= '0;
            trig_addr <= '0;
        end else begin
            state <= state_nxt;
            // Pointer survives the rearm
            if (write) begin
                addr <= (addr == ADDR_LAST) ? '0 : addr + 1'b1;
            end
            if (cnt_clr) begin
                cnt <= '0;
            end else if (write) begin
                cnt <= cnt + 1'b1;
            end
            // Address of the trigger sample itself
            if (trig_take) begin
                trig_addr <= addr;
            end
        end
    end

    // Ready only while holding
    assign status.state         = state;
    assign status.capture_ready = (state == scope_pkg::st_hold);
    assign status.trig_addr     = trig_addr;

endmodule

`default_nettype wire

// ==== sample_ram.sv ====
// Capture buffer memory
`default_nettype none
`timescale 1ns/1ps

`include "scope_config.svh"

module sample_ram (
    input  wire                      ADC_CLK,
    input  wire                      wr_en,
    input  wire [`SCOPE_ADDR_W-1:0]  wr_addr,
    input  wire [`SCOPE_DATA_W-1:0]  wr_data,
    input  wire [`SCOPE_ADDR_W-1:0]  rd_addr,
    output logic [`SCOPE_DATA_W-1:0] rd_data
);

    // ==========================================================
    // Storage
    // ==========================================================

    // One byte per sample
    logic [`SCOPE_DATA_W-1:0] mem [0:`SCOPE_DEPTH-1];

    // Write port from the capture FSM
    always_ff @(posedge ADC_CLK) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ==========================================================
    // Read port
    // ==========================================================

    // Data one cycle after the address
    always_ff @(posedge ADC_CLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== scope_capture_top.sv ====
// Scope acquisition top level
`default_nettype none
`timescale 1ns/1ps

`include "scope_config.svh"

module scope_capture_top (
    input  wire                          ADC_CLK,
    input  wire                          MASTER_RST,
    // ADC sample stream
    input  wire [`SCOPE_DATA_W-1:0]      adc_data,
    input  wire [`SCOPE_TB_W-1:0]        time_base,
    // Trigger setup
    input  wire [`SCOPE_DATA_W-1:0]      trig_level,
    input  wire scope_pkg::slope_e       slope,
    input  wire                          force_trig,
    // Reader side
    input  wire                          read_done,
    input  wire [`SCOPE_ADDR_W-1:0]      rd_addr,
    output logic [`SCOPE_DATA_W-1:0]     rd_data,
    output scope_pkg::capture_status_t   status
);

    // Stage outputs
    scope_pkg::sample_t          dec_sample;
    scope_pkg::sample_t          trig_sample;

    // Buffer write port
    logic                        wr_en;
    logic [`SCOPE_ADDR_W-1:0]    wr_addr;
    logic [`SCOPE_DATA_W-1:0]    wr_data;

    // ==========================================================
    // Sample pipeline
    // ==========================================================

    sample_decimator u_decimator (
        .ADC_CLK    (ADC_CLK),
        .MASTER_RST (MASTER_RST),
        .adc_data   (adc_data),
        .time_base  (time_base),
        .sample     (dec_sample)
    );

    trigger_detector u_trigger (
        .ADC_CLK    (ADC_CLK),
        .MASTER_RST (MASTER_RST),
        .sample_in  (dec_sample),
        .trig_level (trig_level),
        .slope      (slope),
        .force_trig (force_trig),
        .sample_out (trig_sample)
    );

    capture_controller u_controller (
        .ADC_CLK    (ADC_CLK),
        .MASTER_RST (MASTER_RST),
        .sample_in  (trig_sample),
        .read_done  (read_done),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .status     (status)
    );

    // Capture memory
    sample_ram u_ram (
        .ADC_CLK (ADC_CLK),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== tb_scope_capture.sv ====
// Scope capture testbench
`default_nettype none
`timescale 1ns/1ps

`include "scope_config.svh"

module tb_scope_capture;

    localparam int LOG_N   = 16384;
    localparam int N_TESTS = 6;
    localparam int PRE     = `SCOPE_PRE_COUNT;
    localparam int POST    = `SCOPE_POST_COUNT;
    localparam int DEPTH   = `SCOPE_DEPTH;
    // Slowest time base for every test plus margin
    localparam real WATCHDOG_NS = (1 << `SCOPE_TB_W) * DEPTH * N_TESTS * 8.0 + 100000.0;

    logic                        ADC_CLK;
    logic                        MASTER_RST;
    logic [`SCOPE_DATA_W-1:0]    adc_data;
    logic [`SCOPE_TB_W-1:0]      time_base;
    logic [`SCOPE_DATA_W-1:0]    trig_level;
    scope_pkg::slope_e           slope;
    logic                        force_trig;
    logic                        read_done;
    logic [`SCOPE_ADDR_W-1:0]    rd_addr;
    logic [`SCOPE_DATA_W-1:0]    rd_data;
    scope_pkg::capture_status_t  status;

    // Byte driven on each cycle after reset release
    logic [7:0]  byte_log [0:LOG_N-1];
    integer      cyc;
    integer      last_cyc;
    integer      seed;
    integer      data_errs;
    integer      status_errs;
    integer      other_errs;
    // Model results of the latest capture
    integer      exp_taddr;
    integer      exp_tidx;

    scope_capture_top u_scope_capture_top (
        .ADC_CLK    (ADC_CLK),
        .MASTER_RST (MASTER_RST),
        .adc_data   (adc_data),
        .time_base  (time_base),
        .trig_level (trig_level),
        .slope      (slope),
        .force_trig (force_trig),
        .read_done  (read_done),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .status     (status)
    );

    // 8 ns clock
    initial ADC_CLK = 1'b0;
    always #4 ADC_CLK = ~ADC_CLK;

    // ==========================================================
    // Reference model
    // ==========================================================

    // Decimated sample m with one byte every k cycles
    function automatic logic [7:0] sample_at(input integer m, input integer k);
        return byte_log[((m + 1) * k - 1) % LOG_N];
    endfunction

    // First trigger sample after the pre-trigger history
    function automatic integer find_trigger(input integer m0, input integer k,
                                            input scope_pkg::slope_e sl,
                                            input logic [7:0] lvl, input integer f);
        integer      m;
        integer      fm;
        logic [7:0]  p;
        logic [7:0]  c;
        logic        hit;
        // Force lands on the next sample after the pulse
        fm = (f > 0) ? (f + k - 1) / k - 1 : -1;
        for (m = m0 + PRE; (m + 1) * k <= LOG_N; m++) begin
            p = sample_at(m - 1, k);
            c = sample_at(m, k);
            if (sl == scope_pkg::slope_rising) begin
                hit = (p < lvl) && (c >= lvl);
            end else begin
                hit = (p >= lvl) && (c < lvl);
            end
            if (hit || m == fm) begin
                return m;
            end
        end
        return -1;
    endfunction

    // ==========================================================
    // Compare tasks
    // ==========================================================

    task automatic check_data(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_status(input string name, input scope_pkg::capture_status_t exp,
                                input scope_pkg::capture_status_t act);
        if (exp !== act) begin
            $write("CHECK FAILED %s: expected state %0d ready %0d trig_addr %0d",
                   name, exp.state, exp.capture_ready, exp.trig_addr);
            $display(" actual state %0d ready %0d trig_addr %0d",
                     act.state, act.capture_ready, act.trig_addr);
            status_errs++;
        end
    endtask

    // ==========================================================
    // Stimulus helpers
    // ==========================================================

    // One clock with the next logged byte onto the ADC bus
    task automatic step();
        @(posedge ADC_CLK);
        adc_data <= byte_log[cyc % LOG_N];
        last_cyc = cyc;
        cyc = cyc + 1;
    endtask

    task automatic run_to(input integer n);
        while (cyc < n) begin
            step();
        end
    endtask

    // 0 rising ramp, 1 falling ramp, 2 noise below full scale
    task automatic fill_pattern(input integer kind);
        integer n;
        integer ofs;
        ofs = $random(seed) & 255;
        for (n = 0; n < LOG_N; n++) begin
            if (kind == 0) begin
                byte_log[n] = 8'(n + ofs);
            end else if (kind == 1) begin
                byte_log[n] = 8'(ofs - n);
            end else begin
                byte_log[n] = 8'($unsigned($random(seed)) % 255);
            end
        end
    endtask

    // Five cycles of reset with the cycle count restarting at release
    task automatic apply_reset(input logic [2:0] tb, input logic [7:0] lvl,
                               input scope_pkg::slope_e sl);
        @(posedge ADC_CLK);
        MASTER_RST <= 1'b1;
        time_base  <= tb;
        trig_level <= lvl;
        slope      <= sl;
        force_trig <= 1'b0;
        read_done  <= 1'b0;
        repeat (4) @(posedge ADC_CLK);
        cyc = 0;
        step();
        MASTER_RST <= 1'b0;
    endtask

    // Read all addresses from the oldest sample on
    task automatic read_buffer(input string name, input integer t, input integer k,
                               input integer taddr);
        integer i;
        for (i = 0; i < DEPTH; i++) begin
            step();
            rd_addr <= `SCOPE_ADDR_W'((taddr + POST + 1 + i) % DEPTH);
            step();
            @(negedge ADC_CLK);
            check_data(name, sample_at(t - (PRE - 1) + i, k), rd_data);
        end
    endtask

    // Model, optional force pulse, wait for ready, then compare
    task automatic run_capture(input string name, input integer k, input scope_pkg::slope_e sl,
                               input logic [7:0] lvl, input integer f, input integer m0,
                               input integer base);
        scope_pkg::capture_status_t exp;
        exp_tidx = find_trigger(m0, k, sl, lvl, f);
        if (exp_tidx < 0) begin
            $display("%s: reference model found no trigger in the stimulus", name);
            other_errs++;
        end else begin
            exp_taddr = (base + exp_tidx - m0) % DEPTH;
            if (f > 0) begin
                run_to(f);
                step();
                force_trig <= 1'b1;
                step();
                force_trig <= 1'b0;
            end
            while (status.capture_ready !== 1'b1) begin
                step();
                @(negedge ADC_CLK);
            end
            exp.state         = scope_pkg::st_hold;
            exp.capture_ready = 1'b1;
            exp.trig_addr     = `SCOPE_ADDR_W'(exp_taddr);
            check_status(name, exp, status);
            read_buffer(name, exp_tidx, k, exp_taddr);
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial begin
        scope_pkg::capture_status_t st;
        integer d;
        integer m0;
        integer base;
        seed        = 32'had57;
        data_errs   = 0;
        status_errs = 0;
        other_errs  = 0;
        cyc         = 0;
        MASTER_RST  = 1'b1;
        adc_data    = '0;
        time_base   = '0;
        trig_level  = '0;
        slope       = scope_pkg::slope_rising;
        force_trig  = 1'b0;
        read_done   = 1'b0;
        rd_addr     = '0;

        // Reset state then rising ramp at full rate
        fill_pattern(0);
        apply_reset(3'd0, 8'd128, scope_pkg::slope_rising);
        @(negedge ADC_CLK);
        st.state         = scope_pkg::st_arming;
        st.capture_ready = 1'b0;
        st.trig_addr     = '0;
        check_status("after_reset", st, status);
        run_capture("rise_tb0", 1, scope_pkg::slope_rising, 8'd128, -1, 0, 0);

        // Falling ramp with one sample in eight
        fill_pattern(1);
        apply_reset(3'd3, 8'd100, scope_pkg::slope_falling);
        run_capture("fall_tb3", 8, scope_pkg::slope_falling, 8'd100, -1, 0, 0);

        // Ramp crosses the level several times while arming
        fill_pattern(0);
        apply_reset(3'd1, 8'd200, scope_pkg::slope_rising);
        run_capture("arm_ignore", 2, scope_pkg::slope_rising, 8'd200, -1, 0, 0);

        // Level out of reach so only the force pulse triggers
        fill_pattern(2);
        apply_reset(3'd0, 8'd255, scope_pkg::slope_rising);
        run_to(695);
        @(negedge ADC_CLK);
        st.state = scope_pkg::st_wait_trig;
        check_status("no_level_trig", st, status);
        run_capture("force", 1, scope_pkg::slope_rising, 8'd255, 700, 0, 0);

        // Rearm so the second capture wraps the pointer
        step();
        read_done <= 1'b1;
        d = last_cyc;
        step();
        read_done <= 1'b0;
        m0   = d - 1;
        base = (exp_taddr + POST + 1) % DEPTH;
        run_capture("rearm_wrap", 1, scope_pkg::slope_rising, 8'd255, d + 700, m0, base);

        // Idle in hold with the buffer frozen
        repeat (100) step();
        read_buffer("hold_idle", exp_tidx, 1, exp_taddr);

        $display("errors: data %0d status %0d other %0d", data_errs, status_errs, other_errs);
        if (data_errs + status_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired because a capture never completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
scope_pkg.sv
sample_decimator.sv
trigger_detector.sv
capture_controller.sv
sample_ram.sv
scope_capture_top.sv
tb_scope_capture.sv

// ==== Makefile ====
# Verilator build and run for the scope capture testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f all.f --top-module tb_scope_capture -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
